/* common/cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// datapath and register file sizes
`define XLEN        32
`define REG_COUNT   32
`define REG_ADDR_W  5

// boot vector
`define RESET_PC    32'hBFC00000

// ----------------------------------------------------------------------
// instruction field bit positions
// ----------------------------------------------------------------------
`define OPCODE_HI   31
`define OPCODE_LO   26
`define RS_HI       25
`define RS_LO       21
`define RT_HI       20
`define RT_LO       16
`define RD_HI       15
`define RD_LO       11
`define SHAMT_HI    10
`define SHAMT_LO    6
`define FUNCT_HI    5
`define FUNCT_LO    0
`define IMM_HI      15
`define IMM_LO      0

`endif

/* common/cpu_pkg.sv */
`include "cpu_defines.svh"

package cpu_pkg;

    // primary opcodes, R-type goes through special
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_addiu   = 6'h09,
        op_slti    = 6'h0A,
        op_sltiu   = 6'h0B,
        op_andi    = 6'h0C,
        op_ori     = 6'h0D,
        op_xori    = 6'h0E,
        op_lui     = 6'h0F
    } opcode_e;

    // R-type function codes
    typedef enum logic [5:0] {
        fn_sll  = 6'h00,
        fn_srl  = 6'h02,
        fn_sra  = 6'h03,
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_nor  = 6'h27,
        fn_slt  = 6'h2A,
        fn_sltu = 6'h2B
    } funct_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_op_e;

    // ------------------------------------------------------------------
    // stage to stage payloads
    // ------------------------------------------------------------------
    typedef struct packed {
        logic               valid;
        logic [`XLEN-1:0]   pc;
        logic [`XLEN-1:0]   instr;
    } fetch_to_decode_t;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       pc;
        alu_op_e                alu_op;
        logic [`XLEN-1:0]       src_a;
        logic [`XLEN-1:0]       src_b;
        logic [`REG_ADDR_W-1:0] dest;
        logic                   wen;
    } decode_to_exec_t;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       pc;
        logic [`REG_ADDR_W-1:0] dest;
        logic                   wen;
        logic [`XLEN-1:0]       result;
    } exec_to_wb_t;

    // write port from result stage back into the register file
    typedef struct packed {
        logic                   wen;
        logic [`REG_ADDR_W-1:0] dest;
        logic [`XLEN-1:0]       data;
    } rf_write_t;

endpackage

/* hdl/fetch_stage.sv */
`include "cpu_defines.svh"

module fetch_stage (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      decode_allowin,
    input  logic [`XLEN-1:0]          inst_sram_rdata,
    output logic                      inst_sram_en,
    output logic [`XLEN-1:0]          inst_sram_addr,
    output cpu_pkg::fetch_to_decode_t to_decode
);

    logic             en_q;
    logic             valid_q;
    logic [`XLEN-1:0] pc_q;
    logic             advance;

    // move past the word in decode only once decode takes it
    assign advance = valid_q && decode_allowin;

    // a stalled word is simply read again from the held pc
    assign inst_sram_addr = advance ? pc_q + `XLEN'(4) : pc_q;
    assign inst_sram_en   = en_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            en_q    <= 1'b0;
            valid_q <= 1'b0;
            pc_q    <= `RESET_PC;
        end else begin
            en_q <= 1'b1;
            if (en_q) begin
                // pc_q follows the address whose data comes back next cycle
                valid_q <= 1'b1;
                pc_q    <= inst_sram_addr;
            end
        end
    end

    // sram data lines up with pc_q, no extra register
    assign to_decode = '{
        valid: valid_q,
        pc:    pc_q,
        instr: inst_sram_rdata
    };

endmodule

/* decode/reg_file.sv */
`include "cpu_defines.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic [`REG_ADDR_W-1:0] rs_addr,
    input  logic [`REG_ADDR_W-1:0] rt_addr,
    output logic [`XLEN-1:0]       rs_data,
    output logic [`XLEN-1:0]       rt_data,
    input  cpu_pkg::rf_write_t     write
);

    logic [`XLEN-1:0] regs [`REG_COUNT];
    logic             do_write;

    // $zero is never written
    assign do_write = write.wen && (write.dest != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (do_write) begin
            regs[write.dest] <= write.data;
        end
    end

    // same cycle write shows up on the read port
    function automatic logic [`XLEN-1:0] read_port(input logic [`REG_ADDR_W-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (do_write && (write.dest == addr)) begin
            return write.data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs_data = read_port(rs_addr);
        rt_data = read_port(rt_addr);
    end

endmodule

/* decode/decode_stage.sv */
`include "cpu_defines.svh"

module decode_stage (
    input  logic                     clk,
    input  logic                     arst_n,
    input  cpu_pkg::fetch_to_decode_t from_fetch,
    input  cpu_pkg::rf_write_t        rf_write,
    output logic                     allowin,
    output cpu_pkg::decode_to_exec_t  to_exec
);
    import cpu_pkg::*;

    opcode_e                opcode;
    funct_e                 funct;
    logic [`REG_ADDR_W-1:0] rs;
    logic [`REG_ADDR_W-1:0] rt;
    logic [`REG_ADDR_W-1:0] rd;
    logic [4:0]             shamt;
    logic [15:0]            imm;
    logic [`XLEN-1:0]       rs_data;
    logic [`XLEN-1:0]       rt_data;

    alu_op_e                alu_op;
    logic                   kept;
    logic                   r_type;
    logic                   use_rs;
    logic                   a_shamt;
    logic                   imm_signed;
    logic [`REG_ADDR_W-1:0] dest;
    logic                   wen;
    logic [`XLEN-1:0]       src_a;
    logic [`XLEN-1:0]       src_b;
    logic                   hit_rs;
    logic                   hit_rt;
    logic                   stall;

    assign opcode = opcode_e'(from_fetch.instr[`OPCODE_HI:`OPCODE_LO]);
    assign funct  = funct_e'(from_fetch.instr[`FUNCT_HI:`FUNCT_LO]);
    assign rs     = from_fetch.instr[`RS_HI:`RS_LO];
    assign rt     = from_fetch.instr[`RT_HI:`RT_LO];
    assign rd     = from_fetch.instr[`RD_HI:`RD_LO];
    assign shamt  = from_fetch.instr[`SHAMT_HI:`SHAMT_LO];
    assign imm    = from_fetch.instr[`IMM_HI:`IMM_LO];

    reg_file u_reg_file (
        .clk     ( clk      ),
        .arst_n  ( arst_n   ),
        .rs_addr ( rs       ),
        .rt_addr ( rt       ),
        .rs_data ( rs_data  ),
        .rt_data ( rt_data  ),
        .write   ( rf_write )
    );

    // ----------------------------------------------------------------------
    // opcode / funct to alu op
    // ----------------------------------------------------------------------
    always_comb begin
        alu_op     = alu_add;
        kept       = 1'b1;
        r_type     = 1'b0;
        use_rs     = 1'b1;
        a_shamt    = 1'b0;
        imm_signed = 1'b0;
        case (opcode)
            op_special: begin
                r_type = 1'b1;
                case (funct)
                    fn_addu: alu_op = alu_add;
                    fn_subu: alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_xor:  alu_op = alu_xor;
                    fn_nor:  alu_op = alu_nor;
                    fn_slt:  alu_op = alu_slt;
                    fn_sltu: alu_op = alu_sltu;
                    fn_sll, fn_srl, fn_sra: begin
                        // amount comes from the shamt field, not rs
                        use_rs  = 1'b0;
                        a_shamt = 1'b1;
                        if (funct == fn_sll) begin
                            alu_op = alu_sll;
                        end else if (funct == fn_srl) begin
                            alu_op = alu_srl;
                        end else begin
                            alu_op = alu_sra;
                        end
                    end
                    default: kept = 1'b0;
                endcase
            end
            op_addiu: begin
                alu_op     = alu_add;
                imm_signed = 1'b1;
            end
            op_slti: begin
                alu_op     = alu_slt;
                imm_signed = 1'b1;
            end
            // sign extended, compared unsigned
            op_sltiu: begin
                alu_op     = alu_sltu;
                imm_signed = 1'b1;
            end
            op_andi: alu_op = alu_and;
            op_ori:  alu_op = alu_or;
            op_xori: alu_op = alu_xor;
            op_lui: begin
                alu_op = alu_lui;
                use_rs = 1'b0;
            end
            default: kept = 1'b0;
        endcase
    end

    // operands and destination
    assign dest  = r_type ? rd : rt;
    assign wen   = kept && (dest != '0);
    assign src_a = a_shamt ? {{(`XLEN-5){1'b0}}, shamt} : rs_data;
    assign src_b = r_type     ? rt_data :
                   imm_signed ? {{(`XLEN-16){imm[15]}}, imm} :
                                {{(`XLEN-16){1'b0}}, imm};

    // ----------------------------------------------------------------------
    // interlock against the item one stage ahead
    // ----------------------------------------------------------------------
    assign hit_rs  = use_rs && (rs == to_exec.dest);
    assign hit_rt  = r_type && (rt == to_exec.dest);
    assign stall   = from_fetch.valid && to_exec.valid && to_exec.wen && (hit_rs || hit_rt);
    assign allowin = !stall;

    // bubble into execute while stalled
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            to_exec <= '0;
        end else begin
            to_exec <= '{
                valid:  from_fetch.valid && !stall,
                pc:     from_fetch.pc,
                alu_op: alu_op,
                src_a:  src_a,
                src_b:  src_b,
                dest:   dest,
                wen:    wen
            };
        end
    end

endmodule

/* execute/execute_stage.sv */
`include "cpu_defines.svh"

module execute_stage (
    input  cpu_pkg::decode_to_exec_t from_decode,
    output cpu_pkg::exec_to_wb_t     to_wb
);
    import cpu_pkg::*;

    logic [4:0]       shamt;
    logic             lt_signed;
    logic             lt_unsigned;
    logic [`XLEN-1:0] result;

    // only the low five bits count as shift amount
    assign shamt = from_decode.src_a[4:0];

    assign lt_signed   = $signed(from_decode.src_a) < $signed(from_decode.src_b);
    assign lt_unsigned = from_decode.src_a < from_decode.src_b;

    // ----------------------------------------------------------------------
    // alu
    // ----------------------------------------------------------------------
    always_comb begin
        case (from_decode.alu_op)
            alu_add:  result = from_decode.src_a + from_decode.src_b;
            alu_sub:  result = from_decode.src_a - from_decode.src_b;
            alu_and:  result = from_decode.src_a & from_decode.src_b;
            alu_or:   result = from_decode.src_a | from_decode.src_b;
            alu_xor:  result = from_decode.src_a ^ from_decode.src_b;
            alu_nor:  result = ~(from_decode.src_a | from_decode.src_b);
            alu_slt:  result = {{(`XLEN-1){1'b0}}, lt_signed};
            alu_sltu: result = {{(`XLEN-1){1'b0}}, lt_unsigned};
            alu_sll:  result = from_decode.src_b << shamt;
            alu_srl:  result = from_decode.src_b >> shamt;
            alu_sra:  result = $signed(from_decode.src_b) >>> shamt;
            // immediate into the upper half, low half cleared
            alu_lui: begin
                result = {from_decode.src_b[`XLEN/2-1:0], {(`XLEN/2){1'b0}}};
            end
            default:  result = '0;
        endcase
    end

    assign to_wb = '{
        valid:  from_decode.valid,
        pc:     from_decode.pc,
        dest:   from_decode.dest,
        wen:    from_decode.wen,
        result: result
    };

endmodule

/* hdl/writeback_stage.sv */
`include "cpu_defines.svh"

module writeback_stage (
    input  logic                   clk,
    input  logic                   arst_n,
    input  cpu_pkg::exec_to_wb_t   from_exec,
    output cpu_pkg::rf_write_t     rf_write,
    output logic [`XLEN-1:0]       debug_wb_pc,
    output logic [3:0]             debug_wb_rf_wen,
    output logic [`REG_ADDR_W-1:0] debug_wb_rf_wnum,
    output logic [`XLEN-1:0]       debug_wb_rf_wdata
);
    import cpu_pkg::*;

    exec_to_wb_t wb_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_q <= '0;
        end else begin
            wb_q <= from_exec;
        end
    end

    // bubbles never write
    assign rf_write = '{
        wen:  wb_q.valid && wb_q.wen,
        dest: wb_q.dest,
        data: wb_q.result
    };

    // trace port, byte enables all set or all clear
    assign debug_wb_pc       = wb_q.pc;
    assign debug_wb_rf_wen   = {4{rf_write.wen}};
    assign debug_wb_rf_wnum  = rf_write.dest;
    assign debug_wb_rf_wdata = rf_write.data;

endmodule

/* hdl/cpu_core.sv */
`include "cpu_defines.svh"

module cpu_core (
    input  logic                   clk,
    input  logic                   arst_n,
    output logic                   inst_sram_en,
    output logic [`XLEN-1:0]       inst_sram_addr,
    input  logic [`XLEN-1:0]       inst_sram_rdata,
    output logic [`XLEN-1:0]       debug_wb_pc,
    output logic [3:0]             debug_wb_rf_wen,
    output logic [`REG_ADDR_W-1:0] debug_wb_rf_wnum,
    output logic [`XLEN-1:0]       debug_wb_rf_wdata
);
    import cpu_pkg::*;

    fetch_to_decode_t fetch_to_decode;
    decode_to_exec_t  decode_to_exec;
    exec_to_wb_t      exec_to_wb;
    rf_write_t        wb_to_rf;
    logic             decode_allowin;

    fetch_stage u_fetch (
        .clk             ( clk             ),
        .arst_n          ( arst_n          ),
        .decode_allowin  ( decode_allowin  ),
        .inst_sram_rdata ( inst_sram_rdata ),
        .inst_sram_en    ( inst_sram_en    ),
        .inst_sram_addr  ( inst_sram_addr  ),
        .to_decode       ( fetch_to_decode )
    );

    decode_stage u_decode (
        .clk        ( clk             ),
        .arst_n     ( arst_n          ),
        .from_fetch ( fetch_to_decode ),
        .rf_write   ( wb_to_rf        ),
        .allowin    ( decode_allowin  ),
        .to_exec    ( decode_to_exec  )
    );

    execute_stage u_execute (
        .from_decode ( decode_to_exec ),
        .to_wb       ( exec_to_wb     )
    );

    writeback_stage u_writeback (
        .clk               ( clk               ),
        .arst_n            ( arst_n            ),
        .from_exec         ( exec_to_wb        ),
        .rf_write          ( wb_to_rf          ),
        .debug_wb_pc       ( debug_wb_pc       ),
        .debug_wb_rf_wen   ( debug_wb_rf_wen   ),
        .debug_wb_rf_wnum  ( debug_wb_rf_wnum  ),
        .debug_wb_rf_wdata ( debug_wb_rf_wdata )
    );

endmodule

/* tb/tb_clock_gen.sv */
module tb_clock_gen #(
    parameter int PERIOD        = 40,
    parameter int RESET_CYCLES  = 5,
    parameter int RELEASE_DELAY = 2
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release lands just after a rising edge, like the other stimulus
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #(RELEASE_DELAY) arst_n = 1'b1;
    end

endmodule

/* tb/cpu_core_checker.sv */
`include "cpu_defines.svh"

module cpu_core_checker (
    input logic                   clk,
    input logic                   arst_n,
    input logic                   inst_sram_en,
    input logic [`XLEN-1:0]       inst_sram_addr,
    input logic [3:0]             debug_wb_rf_wen,
    input logic [`REG_ADDR_W-1:0] debug_wb_rf_wnum
);

    // number of assertion failures so far
    int fail_count = 0;

    // trace byte enables move together
    wen_all_or_none: assert property (
        @(posedge clk) disable iff (!arst_n)
        debug_wb_rf_wen == 4'h0 || debug_wb_rf_wen == 4'hF
    ) else begin
        $error("debug write enables are neither all set nor all clear");
        fail_count++;
    end

    wen_not_zero_reg: assert property (
        @(posedge clk) disable iff (!arst_n)
        debug_wb_rf_wen != 4'h0 |-> debug_wb_rf_wnum != '0
    ) else begin
        $error("register write reported for register 0");
        fail_count++;
    end

    fetch_aligned: assert property (
        @(posedge clk) disable iff (!arst_n)
        inst_sram_en |-> inst_sram_addr[1:0] == 2'b00
    ) else begin
        $error("instruction fetch address is not word aligned");
        fail_count++;
    end

    // no fetch while the core is held in reset
    fetch_off_in_reset: assert property (
        @(posedge clk) !arst_n |-> !inst_sram_en
    ) else begin
        $error("instruction sram enabled during reset");
        fail_count++;
    end

endmodule

bind cpu_core cpu_core_checker u_checker (
    .clk              ( clk              ),
    .arst_n           ( arst_n           ),
    .inst_sram_en     ( inst_sram_en     ),
    .inst_sram_addr   ( inst_sram_addr   ),
    .debug_wb_rf_wen  ( debug_wb_rf_wen  ),
    .debug_wb_rf_wnum ( debug_wb_rf_wnum )
);

/* tb/cpu_core_tb.sv */
`include "cpu_defines.svh"

module cpu_core_tb;
    import cpu_pkg::*;

    localparam int PERIOD       = 40;
    localparam int RESET_CYCLES = 5;
    localparam int DRIVE_DELAY  = 2;
    localparam int PROG_MAX     = 512;
    localparam int RANDOM_COUNT = 200;
    localparam int DRAIN_CYCLES = 12;

    logic                   clk;
    logic                   arst_n;
    logic                   inst_sram_en;
    logic [`XLEN-1:0]       inst_sram_addr;
    logic [`XLEN-1:0]       inst_sram_rdata;
    logic [`XLEN-1:0]       debug_wb_pc;
    logic [3:0]             debug_wb_rf_wen;
    logic [`REG_ADDR_W-1:0] debug_wb_rf_wnum;
    logic [`XLEN-1:0]       debug_wb_rf_wdata;

    logic [31:0] program_mem [PROG_MAX];
    int          prog_len;
    bit          build_done;
    logic [31:0] rng_state;
    logic [31:0] fetch_addr;
    logic        fetch_en;

    logic [31:0] exp_pc [$];
    logic [4:0]  exp_num [$];
    logic [31:0] exp_data [$];
    int          mismatch_count;
    int          missing_count;
    int          extra_count;
    bit          timed_out;

    tb_clock_gen #(
        .PERIOD        ( PERIOD       ),
        .RESET_CYCLES  ( RESET_CYCLES ),
        .RELEASE_DELAY ( DRIVE_DELAY  )
    ) u_clock_gen (
        .clk    ( clk    ),
        .arst_n ( arst_n )
    );

    cpu_core UUT (
        .clk               ( clk               ),
        .arst_n            ( arst_n            ),
        .inst_sram_en      ( inst_sram_en      ),
        .inst_sram_addr    ( inst_sram_addr    ),
        .inst_sram_rdata   ( inst_sram_rdata   ),
        .debug_wb_pc       ( debug_wb_pc       ),
        .debug_wb_rf_wen   ( debug_wb_rf_wen   ),
        .debug_wb_rf_wnum  ( debug_wb_rf_wnum  ),
        .debug_wb_rf_wdata ( debug_wb_rf_wdata )
    );

    // ----------------------------------------------------------------------
    // program construction
    // ----------------------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic [31:0] r_type(input logic [5:0] funct, input int rs, input int rt,
                                           input int rd, input int shamt);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(shamt), funct};
    endfunction

    function automatic logic [31:0] i_type(input logic [5:0] op, input int rs, input int rt,
                                           input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    task automatic emit(input logic [31:0] word);
        program_mem[prog_len] = word;
        prog_len++;
    endtask

    task automatic load_const(input int r, input logic [31:0] value);
        emit(i_type(op_lui, 0, r, value[31:16]));
        emit(i_type(op_ori, r, r, value[15:0]));
    endtask

    // registers 0..15 only so dependencies and dest 0 come up often
    function automatic logic [31:0] random_instr();
        logic [5:0]  functs [11] = '{fn_addu, fn_subu, fn_and, fn_or, fn_xor, fn_nor,
                                     fn_slt, fn_sltu, fn_sll, fn_srl, fn_sra};
        logic [5:0]  opcodes [7] = '{op_addiu, op_slti, op_sltiu, op_andi, op_ori,
                                     op_xori, op_lui};
        logic [31:0] r;
        int          sel;
        r   = next_random();
        sel = int'(next_random() % 20);
        if (sel < 8) begin
            return r_type(functs[sel], r[3:0], r[7:4], r[11:8], 0);
        end else if (sel < 11) begin
            return r_type(functs[sel], 0, r[7:4], r[11:8], r[20:16]);
        end else if (sel < 18) begin
            return i_type(opcodes[sel - 11], r[3:0], r[7:4], r[31:16]);
        end else if (sel == 18) begin
            return i_type(6'h23, r[3:0], r[7:4], r[31:16]);
        end
        return r_type(6'h1A, r[3:0], r[7:4], r[11:8], 0);
    endfunction

    task automatic build_program();
        prog_len  = 0;
        rng_state = 32'd42054;
        // -16 and 16 split signed and unsigned compares
        load_const(1, 32'hFFFF_FFF0);
        load_const(2, 32'h0000_0010);
        for (int r = 3; r < 8; r++) begin
            load_const(r, next_random());
        end
        emit(r_type(fn_addu, 3, 4, 8, 0));
        emit(r_type(fn_subu, 5, 6, 9, 0));
        emit(r_type(fn_and, 3, 7, 10, 0));
        emit(r_type(fn_or, 4, 5, 11, 0));
        emit(r_type(fn_xor, 6, 7, 12, 0));
        emit(r_type(fn_nor, 3, 5, 13, 0));
        emit(r_type(fn_slt, 1, 2, 14, 0));
        emit(r_type(fn_sltu, 1, 2, 15, 0));
        emit(r_type(fn_slt, 2, 1, 16, 0));
        emit(r_type(fn_sltu, 2, 1, 17, 0));
        emit(r_type(fn_sll, 0, 3, 18, 7));
        emit(r_type(fn_srl, 0, 1, 19, 4));
        emit(r_type(fn_sra, 0, 1, 20, 4));
        emit(r_type(fn_sra, 0, 4, 21, 31));
        // immediates with bit 15 set
        emit(i_type(op_addiu, 2, 22, 16'h8001));
        emit(i_type(op_slti, 2, 23, 16'hFFFF));
        emit(i_type(op_slti, 1, 24, 16'hFFFF));
        emit(i_type(op_sltiu, 2, 25, 16'hFFFF));
        emit(i_type(op_sltiu, 1, 31, 16'hFFFF));
        emit(i_type(op_andi, 1, 26, 16'h8F0F));
        emit(i_type(op_ori, 3, 27, 16'hF00F));
        emit(i_type(op_xori, 1, 28, 16'hAAAA));
        emit(i_type(op_lui, 0, 29, 16'h8765));
        // back to back dependent chain
        emit(i_type(op_addiu, 0, 30, 16'h0001));
        for (int n = 0; n < 4; n++) begin
            emit(r_type(fn_addu, 30, 30, 30, 0));
        end
        emit(r_type(fn_sll, 0, 30, 31, 3));
        emit(r_type(fn_subu, 31, 30, 30, 0));
        // no write expected from these five
        emit(r_type(fn_addu, 1, 2, 0, 0));
        emit(i_type(op_ori, 3, 0, 16'h1234));
        emit(32'h8C22_0004);
        emit(r_type(6'h18, 1, 2, 3, 0));
        emit(32'h0810_0000);
        emit(r_type(fn_addu, 0, 3, 8, 0));
        emit(i_type(op_ori, 0, 9, 16'h0055));
        for (int n = 0; n < RANDOM_COUNT; n++) begin
            emit(random_instr());
        end
    endtask

    // ----------------------------------------------------------------------
    // reference model running in order on its own register file
    // ----------------------------------------------------------------------
    function automatic void run_reference();
        logic [31:0] regs [32];
        logic [31:0] instr;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_s;
        logic [31:0] imm_z;
        logic [31:0] result;
        logic [4:0]  dest;
        logic [4:0]  shamt;
        logic        writes;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int n = 0; n < prog_len; n++) begin
            instr  = program_mem[n];
            a      = regs[instr[25:21]];
            b      = regs[instr[20:16]];
            shamt  = instr[10:6];
            imm_s  = {{16{instr[15]}}, instr[15:0]};
            imm_z  = {16'h0000, instr[15:0]};
            dest   = instr[20:16];
            writes = 1'b1;
            result = '0;
            if (instr[31:26] == op_special) begin
                dest = instr[15:11];
                case (instr[5:0])
                    fn_addu: result = a + b;
                    fn_subu: result = a - b;
                    fn_and:  result = a & b;
                    fn_or:   result = a | b;
                    fn_xor:  result = a ^ b;
                    fn_nor:  result = ~(a | b);
                    fn_slt:  result = {31'b0, $signed(a) < $signed(b)};
                    fn_sltu: result = {31'b0, a < b};
                    fn_sll:  result = b << shamt;
                    fn_srl:  result = b >> shamt;
                    fn_sra:  result = $signed(b) >>> shamt;
                    default: writes = 1'b0;
                endcase
            end else begin
                case (instr[31:26])
                    op_addiu: result = a + imm_s;
                    op_slti:  result = {31'b0, $signed(a) < $signed(imm_s)};
                    op_sltiu: result = {31'b0, a < imm_s};
                    op_andi:  result = a & imm_z;
                    op_ori:   result = a | imm_z;
                    op_xori:  result = a ^ imm_z;
                    op_lui:   result = {instr[15:0], 16'h0000};
                    default:  writes = 1'b0;
                endcase
            end
            if (writes && dest != 5'd0) begin
                regs[dest] = result;
                exp_pc.push_back(`RESET_PC + 32'(4 * n));
                exp_num.push_back(dest);
                exp_data.push_back(result);
            end
        end
    endfunction

    // ----------------------------------------------------------------------
    // instruction sram model with data one cycle after the address
    // ----------------------------------------------------------------------
    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] offset;
        offset = addr - `RESET_PC;
        if (addr >= `RESET_PC && offset[31:2] < 30'(prog_len)) begin
            return program_mem[offset[31:2]];
        end
        // past the program the core only sees nops
        return 32'h0000_0000;
    endfunction

    always @(negedge clk) begin
        fetch_addr = inst_sram_addr;
        fetch_en   = inst_sram_en;
    end

    always @(posedge clk) begin
        #(DRIVE_DELAY);
        if (fetch_en === 1'b1) begin
            inst_sram_rdata = fetch_word(fetch_addr);
        end
    end

    // ----------------------------------------------------------------------
    // checking
    // ----------------------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            mismatch_count++;
        end
    endtask

    task automatic finish_run();
        int assert_fails;
        assert_fails = UUT.u_checker.fail_count;
        $display("summary: %0d mismatches, %0d missing writes, %0d unexpected writes, %0d %s",
                 mismatch_count, missing_count, extra_count, assert_fails,
                 "assertion failures");
        if (mismatch_count == 0 && missing_count == 0 && extra_count == 0 &&
            assert_fails == 0 && !timed_out) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    always @(negedge clk) begin
        if (arst_n === 1'b1 && debug_wb_rf_wen !== 4'h0) begin
            if (exp_pc.size() == 0) begin
                $display("unexpected register write to r%0d from pc 0x%08h",
                         debug_wb_rf_wnum, debug_wb_pc);
                extra_count++;
            end else begin
                check_value("debug_wb_pc", debug_wb_pc, exp_pc.pop_front());
                check_value("debug_wb_rf_wnum", {27'h0, debug_wb_rf_wnum},
                            {27'h0, exp_num.pop_front()});
                check_value("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_data.pop_front());
            end
        end
    end

    // quiet trace in reset and first fetch at the boot vector
    initial begin
        @(negedge clk);
        while (arst_n !== 1'b1) begin
            check_value("debug_wb_rf_wen", {28'h0, debug_wb_rf_wen}, 32'h0);
            check_value("inst_sram_en", {31'h0, inst_sram_en}, 32'h0);
            @(negedge clk);
        end
        check_value("debug_wb_rf_wen", {28'h0, debug_wb_rf_wen}, 32'h0);
        while (inst_sram_en !== 1'b1) begin
            @(negedge clk);
        end
        check_value("inst_sram_addr", inst_sram_addr, `RESET_PC);
    end

    initial begin
        wait (build_done);
        repeat (prog_len * 8 + RESET_CYCLES) @(posedge clk);
        timed_out     = 1'b1;
        missing_count = exp_pc.size();
        $display("timeout, %0d expected register writes never arrived", missing_count);
        finish_run();
    end

    initial begin
        inst_sram_rdata = '0;
        mismatch_count  = 0;
        missing_count   = 0;
        extra_count     = 0;
        timed_out       = 1'b0;
        build_program();
        run_reference();
        build_done = 1'b1;
        wait (arst_n === 1'b1);
        while (exp_pc.size() != 0) begin
            @(posedge clk);
        end
        // extra writes after the last expected one still get caught
        repeat (DRAIN_CYCLES) @(posedge clk);
        finish_run();
    end

endmodule

/* verilog.f */
+incdir+common
common/cpu_pkg.sv
hdl/fetch_stage.sv
decode/reg_file.sv
decode/decode_stage.sv
execute/execute_stage.sv
hdl/writeback_stage.sv
hdl/cpu_core.sv
tb/tb_clock_gen.sv
tb/cpu_core_checker.sv
tb/cpu_core_tb.sv

/* Bender.yml */
package:
  name: cpu_core

sources:
  - include_dirs:
      - common
    files:
      - common/cpu_pkg.sv
      - hdl/fetch_stage.sv
      - decode/reg_file.sv
      - decode/decode_stage.sv
      - execute/execute_stage.sv
      - hdl/writeback_stage.sv
      - hdl/cpu_core.sv
  - target: test
    include_dirs:
      - common
    files:
      - tb/tb_clock_gen.sv
      - tb/cpu_core_checker.sv
      - tb/cpu_core_tb.sv
